// ==== project.f ====
+incdir+.
modsq_arith_pkg.sv
modsq_ctrl_pkg.sv
lut_if.sv
column_adders.sv
square_grid.sv
reduction_lut.sv
modsq_sequencer.sv
modular_reduce.sv
modsq_top.sv
tb_clkgen.sv
tb_modsq.sv

// ==== Bender.yml ====
package:
  name: modsq

export_include_dirs:
  - .

sources:
  - files:
      - modsq_arith_pkg.sv
      - modsq_ctrl_pkg.sv
      - lut_if.sv
      - column_adders.sv
      - square_grid.sv
      - reduction_lut.sv
      - modsq_sequencer.sv
      - modular_reduce.sv
      - modsq_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - tb_modsq.sv

// ==== tb_modsq.sv ====
// iterated modular squarer testbench
`timescale 1ns/1ps
`include "modsq_params.svh"

module tb_modsq;

   localparam int period_ns       = 40;
   localparam int reset_cycles    = 5;
   localparam int num_random      = 30;
   localparam int num_runs        = num_random + 4;  // random, three edge values, redundant
   localparam int iterations      = 12;              // further squarings per run
   localparam int max_wait        = 8;               // cycles allowed before a valid
   localparam int run_cycles      = (iterations + 1) * modsq_ctrl_pkg::num_phases + 20;
   localparam int watchdog_cycles = num_runs * run_cycles + 50;

   localparam logic [63:0] modulus = `MODSQ_MODULUS;

   typedef modsq_arith_pkg::limb_t limbs_t [`MODSQ_NUM_LIMBS];

   logic   clk;
   logic   por_reset;
   logic   run_reset;
   logic   dut_reset;
   logic   start;
   limbs_t sq_in;
   limbs_t sq_out;
   logic   valid;

   tb_clkgen #(
      .period_ns    (period_ns),
      .reset_cycles (reset_cycles)
   ) u_clkgen (
      .clk   (clk),
      .reset (por_reset)
   );

   assign dut_reset = por_reset || run_reset;  // power-on or per-run reset

   modsq_top u_dut (
      .clk    (clk),
      .reset  (dut_reset),
      .start  (start),
      .sq_in  (sq_in),
      .sq_out (sq_out),
      .valid  (valid)
   );

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         abort_run($sformatf("error: %s expected 0x%0h actual 0x%0h", name, expected, actual));
      end
   endtask

   // value of a redundant limb vector modulo the modulus
   function automatic logic [63:0] limbs_value(input limbs_t limbs);
      logic [127:0] acc;
      logic [127:0] term;

      acc = '0;
      for (int i = 0; i < `MODSQ_NUM_LIMBS; i++) begin
         term = 128'(limbs[i]);
         acc  = acc + (term << (`MODSQ_WORD_LEN * i));
      end
      return 64'(acc % {64'd0, modulus});
   endfunction

   function automatic logic [63:0] mod_square(input logic [63:0] x);
      logic [127:0] wide;

      wide = {64'd0, x};
      wide = wide * wide;  // below 2^128, no overflow
      return 64'(wide % {64'd0, modulus});
   endfunction

   // non-redundant form, top limbs zero
   function automatic limbs_t to_limbs(input logic [63:0] x);
      limbs_t limbs;

      for (int i = 0; i < `MODSQ_NONRED_LIMBS; i++) begin
         limbs[i] = modsq_arith_pkg::limb_t'(x[`MODSQ_WORD_LEN*i +: `MODSQ_WORD_LEN]);
      end
      for (int i = `MODSQ_NONRED_LIMBS; i < `MODSQ_NUM_LIMBS; i++) begin
         limbs[i] = '0;
      end
      return limbs;
   endfunction

   // counts sampling points until valid is seen high
   // the previous result must stay on sq_out while waiting
   task automatic wait_valid(input string name, input logic check_hold,
                             input logic [63:0] held, output int cycles);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         if (cycles > max_wait) begin
            abort_run("valid did not arrive within the expected number of cycles");
         end
         if (check_hold && valid !== 1'b1) begin
            check_value({name, " hold"}, held, limbs_value(sq_out));
         end
      end while (valid !== 1'b1);
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #2 run_reset = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #2 run_reset = 1'b0;
   endtask

   task automatic check_idle();
      while (por_reset !== 1'b0) @(negedge clk);
      repeat (8) begin
         @(negedge clk);
         check_value("idle valid", 64'd0, 64'(valid));
      end
   endtask

   task automatic run_test(input string name, input limbs_t x_limbs);
      logic [63:0] expected;
      int          cycles;

      apply_reset();
      sq_in = x_limbs;
      start = 1'b1;
      @(posedge clk);                // start sampled in idle
      #2 start = 1'b0;
      sq_in = '{default: '0};        // input must already be captured

      wait_valid(name, 1'b0, 64'd0, cycles);
      check_value({name, " first latency"}, 64'd4, 64'(cycles));
      expected = mod_square(limbs_value(x_limbs));
      check_value({name, " first square"}, expected, limbs_value(sq_out));

      for (int k = 1; k <= iterations; k++) begin
         wait_valid($sformatf("%s before %0d", name, k), 1'b1, expected, cycles);
         check_value($sformatf("%s period %0d", name, k), 64'd3, 64'(cycles));
         expected = mod_square(expected);  // each result squares the previous one
         check_value($sformatf("%s square %0d", name, k), expected, limbs_value(sq_out));
      end
   endtask

   initial begin : stimulus
      logic [63:0] x;
      limbs_t      limbs;
      int unsigned seed_ret;

      run_reset = 1'b0;
      start     = 1'b0;
      sq_in     = '{default: '0};
      seed_ret  = $urandom(32'h6341_4766);

      check_idle();

      for (int i = 0; i < num_random; i++) begin
         x = {$urandom, $urandom};
         x = x % modulus;
         run_test($sformatf("random %0d", i), to_limbs(x));
      end

      run_test("zero", to_limbs(64'd0));
      run_test("one", to_limbs(64'd1));
      run_test("modulus minus one", to_limbs(modulus - 64'd1));

      // full 17b limbs plus a top limb, value stays below 2^80
      for (int i = 0; i < `MODSQ_NONRED_LIMBS; i++) begin
         limbs[i] = modsq_arith_pkg::limb_t'($urandom);
      end
      limbs[4] = modsq_arith_pkg::limb_t'($urandom % (1 << 15));
      limbs[5] = '0;
      run_test("redundant", limbs);

      $display("PASS: all tests");
      $finish;
   end

   initial begin : watchdog
      #(watchdog_cycles * period_ns);
      abort_run("timeout: the run did not finish in the allowed time");
   end

endmodule

// ==== tb_clkgen.sv ====
// testbench clock and reset
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int period_ns    = 40,
   parameter int reset_cycles = 5
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(period_ns/2) clk = ~clk;
   end

   // power-on reset, released just after a rising edge
   initial begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #2 reset = 1'b0;
   end

endmodule

// ==== modsq_top.sv ====
// iterated modular squarer
`timescale 1ns/1ps
`include "modsq_params.svh"

module modsq_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   start,
   input  modsq_arith_pkg::limb_t sq_in  [`MODSQ_NUM_LIMBS],
   output modsq_arith_pkg::limb_t sq_out [`MODSQ_NUM_LIMBS],
   output logic                   valid
);

   modsq_arith_pkg::limb_t     curr_sq [`MODSQ_NUM_LIMBS];
   modsq_ctrl_pkg::phase_t     phase;
   modsq_arith_pkg::grid_col_t grid_c  [modsq_arith_pkg::num_cols];
   modsq_arith_pkg::grid_col_t grid_s  [modsq_arith_pkg::num_cols];

   lut_if u_lut_if ();

   modsq_sequencer u_seq (
      .clk     (clk),
      .reset   (reset),
      .start   (start),
      .sq_in   (sq_in),
      .sq_out  (sq_out),   // loopback
      .curr_sq (curr_sq),
      .phase   (phase),
      .valid   (valid)
   );

   square_grid u_grid (
      .a (curr_sq),
      .c (grid_c),
      .s (grid_s)
   );

   modular_reduce u_reduce (
      .clk    (clk),
      .phase  (phase),
      .c      (grid_c),
      .s      (grid_s),
      .acc    (u_lut_if.accumulate),
      .sq_out (sq_out)
   );

   reduction_lut u_lut (
      .clk (clk),
      .lk  (u_lut_if.lookup)
   );

endmodule

// ==== modular_reduce.sv ====
// modular reduction of the squared grid
`timescale 1ns/1ps
`include "modsq_params.svh"

module modular_reduce (
   input  logic                       clk,
   input  modsq_ctrl_pkg::phase_t     phase,
   input  modsq_arith_pkg::grid_col_t c [modsq_arith_pkg::num_cols],
   input  modsq_arith_pkg::grid_col_t s [modsq_arith_pkg::num_cols],
   lut_if.accumulate                  acc,
   output modsq_arith_pkg::limb_t     sq_out [`MODSQ_NUM_LIMBS]
);

   localparam int num_limbs     = `MODSQ_NUM_LIMBS;
   localparam int nonred        = `MODSQ_NONRED_LIMBS;
   localparam int num_luts      = modsq_arith_pkg::num_luts;
   localparam int num_acc_terms = 2*num_luts + 1;  // lower words, upper words, low column
   localparam int w             = `MODSQ_WORD_LEN;
   localparam int ext_len       = num_limbs * w;

   modsq_arith_pkg::limb_t    grid_red  [modsq_arith_pkg::num_cols];
   modsq_arith_pkg::limb_t    low_q     [nonred];    // columns below the modulus width
   modsq_arith_pkg::lut_word_t hi_q     [num_luts];  // upper slice residues
   modsq_arith_pkg::acc_col_t acc_terms [num_limbs][num_acc_terms];
   modsq_arith_pkg::acc_col_t acc_c     [num_limbs];
   modsq_arith_pkg::acc_col_t acc_s     [num_limbs];
   modsq_arith_pkg::limb_t    acc_red   [num_limbs];

   carry_reduce #(
      .term_t   (modsq_arith_pkg::grid_col_t),
      .num_cols (modsq_arith_pkg::num_cols)
   ) u_grid_reduce (
      .c       (c),
      .s       (s),
      .reduced (grid_red)
   );

   // upper 9b first, then the lower 8b of each upper column
   always_comb begin
      for (int k = 0; k < num_luts; k++) begin
         if (phase == modsq_ctrl_pkg::phase_0) begin
            acc.addr[k] = grid_red[nonred+k][`MODSQ_BIT_LEN-1:`MODSQ_LOOKUP_WIDTH];
         end else begin
            acc.addr[k] = modsq_arith_pkg::lut_addr_t'(grid_red[nonred+k][`MODSQ_LOOKUP_WIDTH-1:0]);
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int k = 0; k < nonred; k++) begin
         low_q[k] <= grid_red[k];
      end
      if (phase == modsq_ctrl_pkg::phase_1) begin
         hi_q <= acc.data;  // upper slice read issued in phase_0
      end
      if (phase == modsq_ctrl_pkg::phase_2) begin
         sq_out <= acc_red;
      end
   end

   // spread every residue word over the limb columns
   always_comb begin
      logic [ext_len-1:0] lo_ext;
      logic [ext_len-1:0] hi_ext;

      for (int l = 0; l < num_limbs; l++) begin
         acc_terms[l][num_acc_terms-1] = '0;
      end
      for (int l = 0; l < nonred; l++) begin
         acc_terms[l][num_acc_terms-1] = modsq_arith_pkg::acc_col_t'(low_q[l]);
      end
      for (int j = 0; j < num_luts; j++) begin
         lo_ext = acc.data[j];
         hi_ext = hi_q[j];
         hi_ext = hi_ext << `MODSQ_LOOKUP_WIDTH;  // upper slice weighs 2^8 more
         for (int l = 0; l < num_limbs; l++) begin
            acc_terms[l][j]          = modsq_arith_pkg::acc_col_t'(lo_ext[l*w +: w]);
            acc_terms[l][num_luts+j] = modsq_arith_pkg::acc_col_t'(hi_ext[l*w +: w]);
         end
      end
   end

   for (genvar l = 0; l < num_limbs; l++) begin : g_limb
      compressor_tree #(
         .term_t    (modsq_arith_pkg::acc_col_t),
         .num_terms (num_acc_terms)
      ) u_tree (
         .terms (acc_terms[l]),
         .c     (acc_c[l]),
         .s     (acc_s[l])
      );
   end

   carry_reduce #(
      .term_t   (modsq_arith_pkg::acc_col_t),
      .num_cols (num_limbs)
   ) u_acc_reduce (
      .c       (acc_c),
      .s       (acc_s),
      .reduced (acc_red)
   );

endmodule

// ==== modsq_sequencer.sv ====
// squarer loop sequencer
`timescale 1ns/1ps
`include "modsq_params.svh"

module modsq_sequencer (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   start,
   input  modsq_arith_pkg::limb_t sq_in   [`MODSQ_NUM_LIMBS],
   input  modsq_arith_pkg::limb_t sq_out  [`MODSQ_NUM_LIMBS],
   output modsq_arith_pkg::limb_t curr_sq [`MODSQ_NUM_LIMBS],
   output modsq_ctrl_pkg::phase_t phase,
   output logic                   valid
);

   modsq_arith_pkg::limb_t sq_in_q [`MODSQ_NUM_LIMBS];
   modsq_ctrl_pkg::phase_t phase_next;
   logic                   start_flag;  // first squaring uses the captured input
   logic                   accept;

   assign accept = (phase == modsq_ctrl_pkg::idle) && start;  // only from idle

   always_comb begin
      case (phase)
         modsq_ctrl_pkg::idle: begin
            phase_next = accept ? modsq_ctrl_pkg::phase_0 : modsq_ctrl_pkg::idle;
         end
         modsq_ctrl_pkg::phase_0: phase_next = modsq_ctrl_pkg::phase_1;
         modsq_ctrl_pkg::phase_1: phase_next = modsq_ctrl_pkg::phase_2;
         modsq_ctrl_pkg::phase_2: phase_next = modsq_ctrl_pkg::phase_0;  // loops until reset
         default:                 phase_next = modsq_ctrl_pkg::idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         phase      <= modsq_ctrl_pkg::idle;
         valid      <= 1'b0;
         start_flag <= 1'b0;
      end else begin
         phase <= phase_next;
         valid <= (phase == modsq_ctrl_pkg::phase_2);  // sq_out loads on this edge
         if (accept) begin
            start_flag <= 1'b1;
         end else if (phase == modsq_ctrl_pkg::phase_2) begin
            start_flag <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         sq_in_q <= sq_in;
      end
   end

   // loopback select
   always_comb begin
      if (start_flag) begin
         curr_sq = sq_in_q;
      end else begin
         curr_sq = sq_out;
      end
   end

   a_phase_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(phase));

   // a result leaves the loop in phase_0 with the start flag clear
   a_valid_after_p2: assert property (@(posedge clk) disable iff (reset)
      valid |-> (phase == modsq_ctrl_pkg::phase_0) && !start_flag);

   // once running, a result arrives every loop
   a_valid_period: assert property (@(posedge clk) disable iff (reset)
      valid |-> ##(modsq_ctrl_pkg::num_phases) valid);

endmodule

// ==== reduction_lut.sv ====
// reduction lookup tables
`timescale 1ns/1ps
`include "modsq_params.svh"

module reduction_lut (
   input logic   clk,
   lut_if.lookup lk
);

   localparam int num_luts    = modsq_arith_pkg::num_luts;
   localparam int num_entries = 2**(`MODSQ_LOOKUP_WIDTH+1);

   typedef modsq_arith_pkg::lut_word_t rom_t [num_entries];

   // entry v holds v * 2^(16*(col+4)) mod modulus
   function automatic rom_t fill_rom(int col);
      rom_t        rom;
      logic [64:0] modulus;
      logic [64:0] weight;
      logic [64:0] acc;

      modulus = `MODSQ_MODULUS;
      weight  = 65'd1;
      for (int b = 0; b < `MODSQ_WORD_LEN*(col+`MODSQ_NONRED_LIMBS); b++) begin
         weight = weight << 1;  // doubling stays below twice the modulus
         if (weight >= modulus) begin
            weight = weight - modulus;
         end
      end

      acc = '0;
      for (int v = 0; v < num_entries; v++) begin
         rom[v] = modsq_arith_pkg::lut_word_t'(acc);
         acc    = acc + weight;  // next multiple of the column weight
         if (acc >= modulus) begin
            acc = acc - modulus;
         end
      end
      return rom;
   endfunction

   for (genvar k = 0; k < num_luts; k++) begin : g_rom
      localparam rom_t rom = fill_rom(k);

      always_ff @(posedge clk) begin
         lk.data[k] <= rom[lk.addr[k]];  // single registered read port
      end
   end

endmodule

// ==== square_grid.sv ====
// triangular squaring grid
`timescale 1ns/1ps
`include "modsq_params.svh"

module square_grid (
   input  modsq_arith_pkg::limb_t     a [`MODSQ_NUM_LIMBS],
   output modsq_arith_pkg::grid_col_t c [modsq_arith_pkg::num_cols],
   output modsq_arith_pkg::grid_col_t s [modsq_arith_pkg::num_cols]
);

   localparam int num_limbs = `MODSQ_NUM_LIMBS;
   localparam int num_cols  = modsq_arith_pkg::num_cols;
   localparam int w         = `MODSQ_WORD_LEN;

   // first y of the products whose limb indices sum to j
   function automatic int y_min(int j);
      return (j > num_limbs-1) ? j - num_limbs + 1 : 0;
   endfunction

   // products with x >= y and x + y == j
   function automatic int prod_count(int j);
      return (j < 0 || j > 2*num_limbs-2) ? 0 : j/2 - y_min(j) + 1;
   endfunction

   // column i holds high halves from sum i-1, then low halves from sum i
   modsq_arith_pkg::grid_col_t grid [num_cols][num_limbs];

   for (genvar y = 0; y < num_limbs; y++) begin : g_row
      for (genvar x = y; x < num_limbs; x++) begin : g_prod
         localparam int j       = x + y;
         localparam int hi_slot = y - y_min(j);
         localparam int lo_slot = prod_count(j-1) + hi_slot;

         logic [2*`MODSQ_BIT_LEN-1:0] p;

         assign p = a[x] * a[y];

         if (x == y) begin : g_diag
            assign grid[j][lo_slot]   = modsq_arith_pkg::grid_col_t'(p[w-1:0]);
            assign grid[j+1][hi_slot] = modsq_arith_pkg::grid_col_t'(p[2*`MODSQ_BIT_LEN-1:w]);
         end else begin : g_dbl   // a[x]*a[y] appears twice in the square
            assign grid[j][lo_slot]   = modsq_arith_pkg::grid_col_t'({p[w-2:0], 1'b0});
            assign grid[j+1][hi_slot] = modsq_arith_pkg::grid_col_t'(p[2*`MODSQ_BIT_LEN-1:w-1]);
         end
      end
   end

   // edge columns have a single term
   assign c[0]          = '0;
   assign s[0]          = grid[0][0];
   assign c[num_cols-1] = '0;
   assign s[num_cols-1] = grid[num_cols-1][0];

   for (genvar i = 1; i < num_cols-1; i++) begin : g_col
      localparam int n_terms = prod_count(i) + prod_count(i-1);

      compressor_tree #(
         .term_t    (modsq_arith_pkg::grid_col_t),
         .num_terms (n_terms)
      ) u_tree (
         .terms (grid[i][0:n_terms-1]),
         .c     (c[i]),
         .s     (s[i])
      );
   end

endmodule

// ==== column_adders.sv ====
// column compression and carry reduction
`timescale 1ns/1ps
`include "modsq_params.svh"

module compressor_tree #(
   parameter type term_t    = logic [28:0],
   parameter int  num_terms = 3
) (
   input  term_t terms [num_terms],
   output term_t c,
   output term_t s
);

   localparam int num_groups = num_terms / 3;
   localparam int num_left   = num_terms % 3;
   localparam int next_terms = 2*num_groups + num_left;

   initial begin
      assert (num_terms >= 1)
         else $fatal(1, "compressor_tree needs at least one term");
   end

   if (num_terms == 1) begin : g_one
      assign s = terms[0];
      assign c = '0;
   end else if (num_terms == 2) begin : g_two
      assign s = terms[0];  // already in carry-save form
      assign c = terms[1];
   end else begin : g_tree
      term_t level [next_terms];

      // full adders on every group of three
      for (genvar g = 0; g < num_groups; g++) begin : g_csa
         assign level[2*g] = terms[3*g] ^ terms[3*g+1] ^ terms[3*g+2];
         assign level[2*g+1] = ((terms[3*g] & terms[3*g+1]) |
                                (terms[3*g] & terms[3*g+2]) |
                                (terms[3*g+1] & terms[3*g+2])) << 1;
      end

      for (genvar r = 0; r < num_left; r++) begin : g_pass
         assign level[2*num_groups+r] = terms[3*num_groups+r];  // leftovers skip a level
      end

      compressor_tree #(
         .term_t    (term_t),
         .num_terms (next_terms)
      ) u_next (
         .terms (level),
         .c     (c),
         .s     (s)
      );
   end

endmodule

module carry_reduce #(
   parameter type term_t   = logic [28:0],
   parameter int  num_cols = 2
) (
   input  term_t                  c       [num_cols],
   input  term_t                  s       [num_cols],
   output modsq_arith_pkg::limb_t reduced [num_cols]
);

   localparam int term_len = $bits(term_t);

   logic [term_len:0] col_sum [num_cols];  // keeps the final carry

   always_comb begin
      for (int k = 0; k < num_cols; k++) begin
         col_sum[k] = c[k] + s[k];
      end

      reduced[0] = modsq_arith_pkg::limb_t'(col_sum[0][`MODSQ_WORD_LEN-1:0]);
      for (int k = 1; k < num_cols-1; k++) begin
         // low word plus what spilled out of the column below
         reduced[k] = modsq_arith_pkg::limb_t'(col_sum[k][`MODSQ_WORD_LEN-1:0]) +
                      modsq_arith_pkg::limb_t'(col_sum[k-1][term_len:`MODSQ_WORD_LEN]);
      end
      reduced[num_cols-1] = col_sum[num_cols-1][`MODSQ_BIT_LEN-1:0] +  // top keeps 17b
         modsq_arith_pkg::limb_t'(col_sum[num_cols-2][term_len:`MODSQ_WORD_LEN]);
   end

endmodule

// ==== lut_if.sv ====
// reduction lookup bus
`timescale 1ns/1ps

interface lut_if;

   // one address and one residue word per upper grid column
   modsq_arith_pkg::lut_addr_t addr [modsq_arith_pkg::num_luts];
   modsq_arith_pkg::lut_word_t data [modsq_arith_pkg::num_luts];  // one cycle after addr

   // table side
   modport lookup (
      input  addr,
      output data
   );

   // reduction side
   modport accumulate (
      output addr,
      input  data
   );

endinterface

// ==== modsq_ctrl_pkg.sv ====
// squarer loop control types
package modsq_ctrl_pkg;

   localparam int num_phases = 3;  // cycles per squaring

   // one-hot loop phase
   typedef enum logic [3:0] {
      idle    = 4'b0001,
      phase_0 = 4'b0010,  // upper slice lookup
      phase_1 = 4'b0100,  // lower slice lookup
      phase_2 = 4'b1000   // accumulate and load result
   } phase_t;

endpackage

// ==== modsq_arith_pkg.sv ====
// squarer arithmetic types
`include "modsq_params.svh"

package modsq_arith_pkg;

   // 34b product minus the 16b weight step, plus room for doubling and tree growth
   localparam int grid_col_len = 2*`MODSQ_BIT_LEN - `MODSQ_WORD_LEN + 11;

   // limb plus growth bits for up to 17 summed terms
   localparam int acc_col_len  = `MODSQ_BIT_LEN + 12;

   localparam int num_cols = 2*`MODSQ_NUM_LIMBS;                  // square grid columns
   localparam int num_luts = num_cols - `MODSQ_NONRED_LIMBS;      // upper columns to fold

   typedef logic [`MODSQ_BIT_LEN-1:0] limb_t;

   typedef logic [grid_col_len-1:0] grid_col_t;

   typedef logic [acc_col_len-1:0] acc_col_t;

   // upper slice needs the extra bit
   typedef logic [`MODSQ_LOOKUP_WIDTH:0] lut_addr_t;

   // one residue, non-redundant limbs only
   typedef logic [`MODSQ_NONRED_LIMBS*`MODSQ_WORD_LEN-1:0] lut_word_t;

endpackage

// ==== modsq_params.svh ====
// modular squarer parameters
`ifndef MODSQ_PARAMS_SVH
`define MODSQ_PARAMS_SVH

`define MODSQ_NONRED_LIMBS 4   // limbs covering the modulus width
`define MODSQ_RED_LIMBS    2   // headroom for the redundant form
`define MODSQ_NUM_LIMBS    (`MODSQ_NONRED_LIMBS + `MODSQ_RED_LIMBS)

`define MODSQ_BIT_LEN      17  // stored limb width
`define MODSQ_WORD_LEN     16  // limb weight is 2^16
`define MODSQ_LOOKUP_WIDTH 8   // lower slice, upper slice is one bit wider

// odd modulus, the lookup tables are derived from it
`define MODSQ_MODULUS      64'hE3A1_5C7B_9D24_F60F

`endif
